//--- lc3b_pipe.f
+incdir+include
verilog/lc3b_isa_pkg.sv
verilog/lc3b_ctrl_pkg.sv
verilog/lc3b_control_rom.sv
verilog/lc3b_datapath.sv
verilog/lc3b_mem.sv
verilog/lc3b_apb_regs.sv
verilog/lc3b_pipe_top.sv
dv/lc3b_pipe_assert.sv
dv/lc3b_pipe_tb.sv

//--- dv/lc3b_pipe_tb.sv
`include "lc3b_pipe_config.svh"

module lc3b_pipe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF = 20;
    localparam int NUM_TESTS = 26;
    // Budget of 200 cycles per test plus room for the imem fill
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 2000;
    localparam logic [15:0] NOP = 16'h0000;

    logic clk, rst_n, psel, penable, pwrite, pready, pslverr;
    logic [11:0] paddr;
    logic [15:0] pwdata, prdata;

    // Reference model state
    logic [15:0] img [256];
    logic [15:0] dm [256];
    logic [15:0] mregs [8];
    logic [15:0] prog [$];
    int mcount;
    logic [31:0] rng;

    lc3b_pipe_top u_lc3b_pipe_top (.*);

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        stop_on_error();
    end

    initial begin
        wait (u_lc3b_pipe_top.u_assert.fail_count != 0);
        $display("A bound assertion on the DUT failed");
        stop_on_error();
    end

    // One APB transfer with zero wait states, then an idle cycle
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [15:0] data,
                            output logic [15:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(HALF / 2);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [15:0] data);
        logic [15:0] rd;
        logic err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value("apb write pslverr", 16'h0, 16'(err));
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [15:0] data);
        logic err;
        apb_xfer(1'b0, addr, 16'h0, data, err);
        check_value("apb read pslverr", 16'h0, 16'(err));
    endtask

    function automatic logic [4:0] rand_imm5();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng[4:0];
    endfunction

    // Instruction encoders
    function automatic logic [15:0] add_imm(int dr, int sr, logic [4:0] imm);
        return {4'h1, 3'(dr), 3'(sr), 1'b1, imm};
    endfunction
    function automatic logic [15:0] add_reg(int dr, int sr1, int sr2);
        return {4'h1, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction
    function automatic logic [15:0] and_imm(int dr, int sr, logic [4:0] imm);
        return {4'h5, 3'(dr), 3'(sr), 1'b1, imm};
    endfunction
    function automatic logic [15:0] and_reg(int dr, int sr1, int sr2);
        return {4'h5, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction
    function automatic logic [15:0] not_reg(int dr, int sr);
        return {4'h9, 3'(dr), 3'(sr), 6'h3F};
    endfunction
    function automatic logic [15:0] ldr_word(int dr, int base, logic [5:0] off);
        return {4'h6, 3'(dr), 3'(base), off};
    endfunction
    function automatic logic [15:0] str_word(int sr, int base, logic [5:0] off);
        return {4'h7, 3'(sr), 3'(base), off};
    endfunction
    function automatic logic [15:0] branch(logic [2:0] nzp, logic [8:0] off);
        return {4'h0, nzp, off};
    endfunction
    function automatic logic [15:0] jump(int base);
        return {4'hC, 3'b000, 3'(base), 6'h00};
    endfunction

    task automatic emit_nops(input int n);
        repeat (n) prog.push_back(NOP);
    endtask

    // Sequential model with four delay slots after a taken transfer
    task automatic model_run(input logic [15:0] start);
        logic [15:0] pc, ir, res, tgt, addr, opnd;
        logic [2:0] cc;
        logic wr;
        int slots;
        pc = start;
        cc = 3'b010;
        mcount = 0;
        slots = 0;
        tgt = '0;
        while (mcount < 1000) begin
            ir = img[pc[8:1]];
            mcount++;
            if (ir[15:12] == 4'hF) break;
            wr = 1'b0;
            res = '0;
            opnd = ir[5] ? {{11{ir[4]}}, ir[4:0]} : mregs[ir[2:0]];
            addr = mregs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            case (ir[15:12])
                4'h1: {wr, res} = {1'b1, mregs[ir[8:6]] + opnd};
                4'h5: {wr, res} = {1'b1, mregs[ir[8:6]] & opnd};
                4'h9: {wr, res} = {1'b1, ~mregs[ir[8:6]]};
                4'h6: {wr, res} = {1'b1, dm[addr[8:1]]};
                4'h7: dm[addr[8:1]] = mregs[ir[11:9]];
                4'h0: begin
                    if (|(ir[11:9] & cc)) begin
                        tgt = pc + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};
                        slots = 5;
                    end
                end
                4'hC: begin
                    tgt = mregs[ir[8:6]];
                    slots = 5;
                end
                default: ;
            endcase
            if (wr) begin
                mregs[ir[11:9]] = res;
                cc = {res[15], res == 16'h0, !res[15] && res != 16'h0};
            end
            pc = pc + 16'd2;
            if (slots > 0) begin
                slots--;
                if (slots == 0) pc = tgt;
            end
        end
    endtask

    // Appends TRAP and its shadow NOPs, then writes the image
    task automatic load_prog(input logic [15:0] start);
        int idx;
        prog.push_back(16'hF025);
        emit_nops(4);
        foreach (prog[i]) begin
            idx = (int'(start[8:1]) + i) % 256;
            img[idx] = prog[i];
            apb_write(12'(`LC3B_WIN_IMEM + idx * 4), prog[i]);
        end
        prog.delete();
        apb_write(`LC3B_ADDR_START_PC, start);
        apb_write(`LC3B_ADDR_CTRL, 16'h0001);
    endtask

    task automatic finish_prog(input string name, input logic [15:0] start);
        logic [15:0] st, rd;
        do begin
            apb_read(`LC3B_ADDR_STATUS, st);
        end while (st[0] !== 1'b1);
        model_run(start);
        check_value({name, " status"}, 16'h0001, st);
        apb_read(`LC3B_ADDR_CTRL, rd);
        check_value({name, " ctrl"}, 16'h0000, rd);
        apb_read(`LC3B_ADDR_RETIRED, rd);
        check_value({name, " retired"}, 16'(mcount), rd);
        for (int i = 0; i < 8; i++) begin
            apb_read(12'(`LC3B_WIN_REG + i * 4), rd);
            check_value($sformatf("%s r%0d", name, i), mregs[i], rd);
        end
    endtask

    initial begin
        logic [15:0] rd, start, tgt;
        logic err;
        int idx;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rng     = 32'd88459;
        for (int i = 0; i < 8; i++) mregs[i] = '0;
        for (int i = 0; i < 256; i++) dm[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values and an unmapped read
        apb_read(`LC3B_ADDR_CTRL, rd);
        check_value("reset ctrl", 16'h0, rd);
        apb_read(`LC3B_ADDR_STATUS, rd);
        check_value("reset status", 16'h0, rd);
        apb_read(`LC3B_ADDR_RETIRED, rd);
        check_value("reset retired", 16'h0, rd);
        apb_xfer(1'b0, 12'h030, 16'h0, rd, err);
        check_value("unmapped read", 16'h0, rd);
        check_value("unmapped pslverr", 16'h0, 16'(err));

        // Fill imem with never-taken branches whose offset is the address
        for (int i = 0; i < 256; i++) begin
            img[i] = 16'(i);
            apb_write(12'(`LC3B_WIN_IMEM + i * 4), img[i]);
        end

        // ALU forms
        prog.push_back(add_imm(1, 0, rand_imm5()));
        prog.push_back(add_imm(2, 0, rand_imm5()));
        emit_nops(4);
        prog.push_back(add_reg(3, 1, 2));
        prog.push_back(and_reg(4, 1, 2));
        prog.push_back(and_imm(5, 1, rand_imm5()));
        prog.push_back(not_reg(6, 2));
        load_prog(16'h0000);
        finish_prog("alu", 16'h0000);

        // Store then load
        prog.push_back(and_imm(7, 7, 5'd0));
        emit_nops(4);
        prog.push_back(add_imm(1, 7, rand_imm5()));
        emit_nops(4);
        prog.push_back(str_word(1, 7, 6'd5));
        emit_nops(4);
        prog.push_back(ldr_word(2, 7, 6'd5));
        load_prog(16'h0040);
        finish_prog("store_load", 16'h0040);
        apb_read(12'(`LC3B_WIN_DMEM + 5 * 4), rd);
        check_value("store_load dmem", dm[5], rd);

        // Branches and jump with marker registers r3, r4, r5
        start = 16'h0080;
        prog.push_back(and_imm(3, 3, 5'd0));
        prog.push_back(and_imm(4, 4, 5'd0));
        prog.push_back(and_imm(5, 5, 5'd0));
        prog.push_back(ldr_word(2, 0, 6'd7));
        prog.push_back(and_imm(6, 6, 5'd0));
        prog.push_back(branch(3'b010, 9'd5));
        emit_nops(4);
        prog.push_back(add_imm(3, 3, 5'd1));
        prog.push_back(branch(3'b100, 9'd0));
        prog.push_back(add_imm(4, 4, 5'd1));
        tgt = start + 16'(2 * (prog.size() + 6));
        prog.push_back(jump(2));
        emit_nops(4);
        prog.push_back(add_imm(5, 5, 5'd1));
        prog.push_back(add_imm(5, 5, 5'd2));
        dm[7] = tgt;
        apb_write(12'(`LC3B_WIN_DMEM + 7 * 4), tgt);
        load_prog(start);
        finish_prog("branch", start);
        apb_read(12'(`LC3B_WIN_REG + 3 * 4), rd);
        check_value("branch taken skip", 16'h0, rd);
        apb_read(12'(`LC3B_WIN_REG + 4 * 4), rd);
        check_value("branch fall through", 16'h1, rd);
        apb_read(12'(`LC3B_WIN_REG + 5 * 4), rd);
        check_value("jump target", 16'h2, rd);

        // Write refused while running, then halt
        start = 16'h0100;
        emit_nops(30);
        load_prog(start);
        apb_xfer(1'b1, 12'(`LC3B_WIN_IMEM + 130 * 4), 16'hDEAD, rd, err);
        check_value("locked write pslverr", 16'h1, 16'(err));
        finish_prog("halt", start);
        apb_read(12'(`LC3B_WIN_IMEM + 130 * 4), rd);
        check_value("locked write imem", img[130], rd);

        // Random add-immediate chains
        for (int t = 0; t < 20; t++) begin
            void'(rand_imm5());
            idx = int'(rng % 200);
            start = 16'(idx * 2);
            prog.push_back(add_imm(1, 1, rand_imm5()));
            emit_nops(4);
            prog.push_back(add_imm(2, 1, rand_imm5()));
            emit_nops(4);
            prog.push_back(add_imm(1, 2, rand_imm5()));
            load_prog(start);
            finish_prog($sformatf("chain%0d", t), start);
        end

        if (u_lc3b_pipe_top.u_assert.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : lc3b_pipe_tb

//--- dv/lc3b_pipe_assert.sv
module lc3b_pipe_assert (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic run,
    input logic launch,
    input logic halt,
    input logic d_we,
    input logic retire
);
    timeunit 1ns;
    timeprecision 1ps;

    lc3b_ctrl_pkg::apb_state_e apb_phase;
    int fail_count = 0;

    assign apb_phase = !psel ? lc3b_ctrl_pkg::apb_idle :
                       !penable ? lc3b_ctrl_pkg::apb_setup : lc3b_ctrl_pkg::apb_access;

    pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> apb_phase == lc3b_ctrl_pkg::apb_access)
        else begin
            $error("pslverr outside an access phase");
            fail_count++;
        end

    pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb_phase == lc3b_ctrl_pkg::apb_access |-> pready)
        else begin
            $error("pready low in an access phase");
            fail_count++;
        end

    launch_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        launch |=> !launch)
        else begin
            $error("launch longer than one cycle");
            fail_count++;
        end

    // Halt stops the core on the next cycle
    run_clear_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halt |=> !run)
        else begin
            $error("run still set after halt");
            fail_count++;
        end

    no_store_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> !d_we)
        else begin
            $error("data store while the core is stopped");
            fail_count++;
        end

    no_retire_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> !retire)
        else begin
            $error("retire while the core is stopped");
            fail_count++;
        end

endmodule : lc3b_pipe_assert

bind lc3b_pipe_top lc3b_pipe_assert u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .run(run),
    .launch(launch),
    .halt(halt),
    .d_we(d_we),
    .retire(retire)
);

//--- verilog/lc3b_pipe_top.sv
`include "lc3b_pipe_config.svh"

module lc3b_pipe_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  lc3b_isa_pkg::word_t pwdata,
    output lc3b_isa_pkg::word_t prdata,
    output logic                pready,
    output logic                pslverr
);

    localparam int IMEM_AW = $clog2(`LC3B_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`LC3B_DMEM_WORDS);

    logic run, launch, retire, halt, imem_we, dmem_we, d_we;
    logic [7:0] mem_addr;
    lc3b_isa_pkg::word_t start_pc, mem_wdata, imem_rdata, dmem_rdata, dbg_data;
    lc3b_isa_pkg::word_t i_addr, i_rdata, d_addr, d_wdata, d_rdata;
    lc3b_isa_pkg::reg_t dbg_reg;
    // Control ROM fields
    lc3b_isa_pkg::opcode_e opcode;
    logic ir_5, load_regfile, load_cc, d_we_ctl, is_br, is_jmp, is_trap;
    lc3b_ctrl_pkg::alu_op_e alu_op;
    lc3b_ctrl_pkg::alumux_sel_e alumux_sel;
    lc3b_ctrl_pkg::wbmux_sel_e wbmux_sel;

    lc3b_apb_regs u_apb_regs (.*);

    lc3b_datapath u_datapath (.*);

    lc3b_control_rom u_control_rom (.*);

    // Byte addresses from the core, word index into the arrays
    lc3b_mem #(.DEPTH(`LC3B_IMEM_WORDS)) u_imem (
        .clk,
        .core_addr(i_addr[IMEM_AW:1]),
        .core_wdata('0),
        .core_we(1'b0),
        .core_rdata(i_rdata),
        .apb_addr(mem_addr[IMEM_AW-1:0]),
        .apb_wdata(mem_wdata),
        .apb_we(imem_we),
        .apb_rdata(imem_rdata)
    );

    lc3b_mem #(.DEPTH(`LC3B_DMEM_WORDS)) u_dmem (
        .clk,
        .core_addr(d_addr[DMEM_AW:1]),
        .core_wdata(d_wdata),
        .core_we(d_we),
        .core_rdata(d_rdata),
        .apb_addr(mem_addr[DMEM_AW-1:0]),
        .apb_wdata(mem_wdata),
        .apb_we(dmem_we),
        .apb_rdata(dmem_rdata)
    );

endmodule : lc3b_pipe_top

//--- verilog/lc3b_apb_regs.sv
`include "lc3b_pipe_config.svh"

module lc3b_apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  lc3b_isa_pkg::word_t pwdata,
    output lc3b_isa_pkg::word_t prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                run,
    output logic                launch,
    output lc3b_isa_pkg::word_t start_pc,
    input  logic                retire,
    input  logic                halt,
    output logic                imem_we,
    output logic                dmem_we,
    output logic [7:0]          mem_addr,
    output lc3b_isa_pkg::word_t mem_wdata,
    input  lc3b_isa_pkg::word_t imem_rdata,
    input  lc3b_isa_pkg::word_t dmem_rdata,
    output lc3b_isa_pkg::reg_t  dbg_reg,
    input  lc3b_isa_pkg::word_t dbg_data
);

    lc3b_ctrl_pkg::apb_state_e apb_state;
    logic wr_en, imem_hit, dmem_hit, regwin_hit, locked, halted;
    lc3b_isa_pkg::word_t retired;

    always_comb begin
        if (!psel) begin
            apb_state = lc3b_ctrl_pkg::apb_idle;
        end else if (!penable) begin
            apb_state = lc3b_ctrl_pkg::apb_setup;
        end else begin
            apb_state = lc3b_ctrl_pkg::apb_access;
        end
    end

    // Address decode, 1 KB per memory window
    assign imem_hit   = (paddr & 12'hC00) == `LC3B_WIN_IMEM;
    assign dmem_hit   = (paddr & 12'hC00) == `LC3B_WIN_DMEM;
    assign regwin_hit = (paddr & 12'hFE0) == `LC3B_WIN_REG;

    assign wr_en   = (apb_state == lc3b_ctrl_pkg::apb_access) && pwrite;
    // Memories and the start PC are frozen while the core runs
    assign locked  = run && (imem_hit || dmem_hit || paddr == `LC3B_ADDR_START_PC);
    assign pslverr = wr_en && locked;
    assign pready  = 1'b1;

    assign imem_we   = wr_en && imem_hit && !run;
    assign dmem_we   = wr_en && dmem_hit && !run;
    assign mem_addr  = paddr[9:2];
    assign mem_wdata = pwdata;
    assign dbg_reg   = paddr[4:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            launch   <= 1'b0;
            halted   <= 1'b0;
            start_pc <= '0;
            retired  <= '0;
        end else begin
            launch <= 1'b0;
            if (launch) begin
                retired <= '0;
                halted  <= 1'b0;
            end else if (retire) begin
                retired <= retired + 1'b1;
            end
            // Halt beats a CTRL write in the same cycle
            if (halt) begin
                run    <= 1'b0;
                halted <= 1'b1;
            end else if (wr_en && paddr == `LC3B_ADDR_CTRL) begin
                run    <= pwdata[0];
                launch <= pwdata[0] && !run;
            end
            if (wr_en && paddr == `LC3B_ADDR_START_PC && !run) begin
                start_pc <= pwdata;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (imem_hit) begin
            prdata = imem_rdata;
        end else if (dmem_hit) begin
            prdata = dmem_rdata;
        end else if (regwin_hit) begin
            prdata = dbg_data;
        end else begin
            case (paddr)
                `LC3B_ADDR_CTRL:     prdata = lc3b_isa_pkg::word_t'(run);
                `LC3B_ADDR_START_PC: prdata = start_pc;
                `LC3B_ADDR_STATUS:   prdata = lc3b_isa_pkg::word_t'({run, halted});
                `LC3B_ADDR_RETIRED:  prdata = retired;
                default:             prdata = '0;
            endcase
        end
    end

endmodule : lc3b_apb_regs

//--- verilog/lc3b_mem.sv
module lc3b_mem #(
    parameter int DEPTH = 256
) (
    input  logic                       clk,
    input  logic [$clog2(DEPTH)-1:0]   core_addr,
    input  lc3b_isa_pkg::word_t        core_wdata,
    input  logic                       core_we,
    output lc3b_isa_pkg::word_t        core_rdata,
    input  logic [$clog2(DEPTH)-1:0]   apb_addr,
    input  lc3b_isa_pkg::word_t        apb_wdata,
    input  logic                       apb_we,
    output lc3b_isa_pkg::word_t        apb_rdata
);

    lc3b_isa_pkg::word_t mem [DEPTH];

    // APB writes only happen with the core stopped, so they win
    always_ff @(posedge clk) begin
        if (apb_we) begin
            mem[apb_addr] <= apb_wdata;
        end else if (core_we) begin
            mem[core_addr] <= core_wdata;
        end
    end

    // Core read takes one cycle
    always_ff @(posedge clk) begin
        core_rdata <= mem[core_addr];
    end

    // Window reads complete in the access phase
    assign apb_rdata = mem[apb_addr];

endmodule : lc3b_mem

//--- verilog/lc3b_datapath.sv
module lc3b_datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       launch,
    input  lc3b_isa_pkg::word_t        start_pc,
    output lc3b_isa_pkg::word_t        i_addr,
    input  lc3b_isa_pkg::word_t        i_rdata,
    output lc3b_isa_pkg::word_t        d_addr,
    output lc3b_isa_pkg::word_t        d_wdata,
    output logic                       d_we,
    input  lc3b_isa_pkg::word_t        d_rdata,
    input  lc3b_isa_pkg::reg_t         dbg_reg,
    output lc3b_isa_pkg::word_t        dbg_data,
    output logic                       retire,
    output logic                       halt,
    output lc3b_isa_pkg::opcode_e      opcode,
    output logic                       ir_5,
    input  lc3b_ctrl_pkg::alu_op_e     alu_op,
    input  lc3b_ctrl_pkg::alumux_sel_e alumux_sel,
    input  lc3b_ctrl_pkg::wbmux_sel_e  wbmux_sel,
    input  logic                       load_regfile,
    input  logic                       load_cc,
    input  logic                       d_we_ctl,
    input  logic                       is_br,
    input  logic                       is_jmp,
    input  logic                       is_trap
);

    logic advance;
    lc3b_isa_pkg::word_t pc, pc_next;
    lc3b_isa_pkg::word_t regs [8];
    lc3b_isa_pkg::nzp_t cc;
    // IF/ID, the instruction itself comes straight from the imem read register
    logic id_valid;
    lc3b_isa_pkg::word_t id_pc, id_pc2, id_ir, id_src1, id_src2, id_tgt;
    lc3b_isa_pkg::reg_t id_sr2;
    // ID/EX
    logic ex_valid, ex_load_regfile, ex_load_cc, ex_d_we, ex_is_br, ex_is_jmp, ex_is_trap;
    lc3b_ctrl_pkg::alu_op_e ex_alu_op;
    lc3b_ctrl_pkg::alumux_sel_e ex_alumux_sel;
    lc3b_ctrl_pkg::wbmux_sel_e ex_wbmux_sel;
    lc3b_isa_pkg::reg_t ex_dest;
    lc3b_isa_pkg::word_t ex_a, ex_b, ex_tgt, ex_opnd, ex_alu;
    logic [5:0] ex_imm;
    // EX/MEM
    logic mem_valid, mem_load_regfile, mem_load_cc, mem_d_we, mem_is_br, mem_is_jmp, mem_is_trap;
    lc3b_ctrl_pkg::wbmux_sel_e mem_wbmux_sel;
    lc3b_isa_pkg::reg_t mem_dest;
    lc3b_isa_pkg::word_t mem_alu, mem_sdata, mem_tgt;
    // MEM/WB
    logic wb_valid, wb_load_regfile, wb_load_cc, wb_is_br, wb_is_jmp, wb_is_trap, br_en;
    lc3b_ctrl_pkg::wbmux_sel_e wb_wbmux_sel;
    lc3b_isa_pkg::reg_t wb_dest;
    lc3b_isa_pkg::word_t wb_alu, wb_tgt, wb_data;

    assign advance = run && !launch;

    // While frozen the memories re-read the addresses of the held stages
    assign i_addr = advance ? pc : id_pc;
    assign d_addr = advance ? mem_alu : wb_alu;

    // ID
    assign id_ir   = i_rdata;
    assign opcode  = lc3b_isa_pkg::opcode_e'(id_ir[15:12]);
    assign ir_5    = id_ir[5];
    assign id_pc2  = id_pc + lc3b_isa_pkg::word_t'(2);
    assign id_sr2  = d_we_ctl ? id_ir[11:9] : id_ir[2:0];
    assign id_src1 = regs[id_ir[8:6]];
    assign id_src2 = regs[id_sr2];
    assign id_tgt  = id_pc2 + {{6{id_ir[8]}}, id_ir[8:0], 1'b0};
    assign dbg_data = regs[dbg_reg];

    // EX
    always_comb begin
        case (ex_alumux_sel)
            lc3b_ctrl_pkg::alumux_imm5: ex_opnd = {{11{ex_imm[4]}}, ex_imm[4:0]};
            lc3b_ctrl_pkg::alumux_off6: ex_opnd = {{9{ex_imm[5]}}, ex_imm, 1'b0};
            default:                    ex_opnd = ex_b;
        endcase
        case (ex_alu_op)
            lc3b_ctrl_pkg::alu_add: ex_alu = ex_a + ex_opnd;
            lc3b_ctrl_pkg::alu_and: ex_alu = ex_a & ex_opnd;
            lc3b_ctrl_pkg::alu_not: ex_alu = ~ex_a;
            default:                ex_alu = ex_a;
        endcase
    end

    // MEM
    assign d_wdata = mem_sdata;
    assign d_we    = advance && mem_valid && mem_d_we;

    // WB, the dest field holds the nzp mask for BR
    assign wb_data = (wb_wbmux_sel == lc3b_ctrl_pkg::wbmux_mem) ? d_rdata : wb_alu;
    assign br_en   = |(wb_dest & cc);
    assign retire  = advance && wb_valid;
    assign halt    = advance && wb_valid && wb_is_trap;

    always_comb begin
        pc_next = pc + lc3b_isa_pkg::word_t'(2);
        if (wb_valid && wb_is_br && br_en) begin
            pc_next = wb_tgt;
        end else if (wb_valid && wb_is_jmp) begin
            pc_next = wb_alu;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= '0;
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else if (launch) begin
            pc        <= start_pc;
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else if (advance) begin
            pc        <= pc_next;
            id_valid  <= 1'b1;
            ex_valid  <= id_valid;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_pc            <= pc;
            ex_alu_op        <= alu_op;
            ex_alumux_sel    <= alumux_sel;
            ex_wbmux_sel     <= wbmux_sel;
            ex_load_regfile  <= load_regfile;
            ex_load_cc       <= load_cc;
            ex_d_we          <= d_we_ctl;
            ex_is_br         <= is_br;
            ex_is_jmp        <= is_jmp;
            ex_is_trap       <= is_trap;
            ex_dest          <= id_ir[11:9];
            ex_a             <= id_src1;
            ex_b             <= id_src2;
            ex_imm           <= id_ir[5:0];
            ex_tgt           <= id_tgt;
            mem_wbmux_sel    <= ex_wbmux_sel;
            mem_load_regfile <= ex_load_regfile;
            mem_load_cc      <= ex_load_cc;
            mem_d_we         <= ex_d_we;
            mem_is_br        <= ex_is_br;
            mem_is_jmp       <= ex_is_jmp;
            mem_is_trap      <= ex_is_trap;
            mem_dest         <= ex_dest;
            mem_alu          <= ex_alu;
            mem_sdata        <= ex_b;
            mem_tgt          <= ex_tgt;
            wb_wbmux_sel     <= mem_wbmux_sel;
            wb_load_regfile  <= mem_load_regfile;
            wb_load_cc       <= mem_load_cc;
            wb_is_br         <= mem_is_br;
            wb_is_jmp        <= mem_is_jmp;
            wb_is_trap       <= mem_is_trap;
            wb_dest          <= mem_dest;
            wb_alu           <= mem_alu;
            wb_tgt           <= mem_tgt;
        end
    end

    // Register file and condition code, written in WB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            cc <= 3'b010;
        end else if (launch) begin
            cc <= 3'b010;
        end else if (advance && wb_valid) begin
            if (wb_load_regfile) begin
                regs[wb_dest] <= wb_data;
            end
            if (wb_load_cc) begin
                cc <= {$signed(wb_data) < 0, wb_data == '0, $signed(wb_data) > 0};
            end
        end
    end

endmodule : lc3b_datapath

//--- verilog/lc3b_control_rom.sv
module lc3b_control_rom (
    input  lc3b_isa_pkg::opcode_e      opcode,
    input  logic                       ir_5,
    output lc3b_ctrl_pkg::alu_op_e     alu_op,
    output lc3b_ctrl_pkg::alumux_sel_e alumux_sel,
    output lc3b_ctrl_pkg::wbmux_sel_e  wbmux_sel,
    output logic                       load_regfile,
    output logic                       load_cc,
    output logic                       d_we_ctl,
    output logic                       is_br,
    output logic                       is_jmp,
    output logic                       is_trap
);

    always_comb begin
        alu_op       = lc3b_ctrl_pkg::alu_pass;
        alumux_sel   = lc3b_ctrl_pkg::alumux_reg;
        wbmux_sel    = lc3b_ctrl_pkg::wbmux_alu;
        load_regfile = 1'b0;
        load_cc      = 1'b0;
        d_we_ctl     = 1'b0;
        is_br        = 1'b0;
        is_jmp       = 1'b0;
        is_trap      = 1'b0;
        case (opcode)
            lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
                alu_op = (opcode == lc3b_isa_pkg::op_add) ? lc3b_ctrl_pkg::alu_add
                                                          : lc3b_ctrl_pkg::alu_and;
                // IR[5] picks imm5 over SR2
                alumux_sel   = ir_5 ? lc3b_ctrl_pkg::alumux_imm5 : lc3b_ctrl_pkg::alumux_reg;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            lc3b_isa_pkg::op_not: begin
                alu_op       = lc3b_ctrl_pkg::alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            lc3b_isa_pkg::op_ldr: begin
                alu_op       = lc3b_ctrl_pkg::alu_add;
                alumux_sel   = lc3b_ctrl_pkg::alumux_off6;
                wbmux_sel    = lc3b_ctrl_pkg::wbmux_mem;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            lc3b_isa_pkg::op_str: begin
                // Store data rides on the second read port
                alu_op     = lc3b_ctrl_pkg::alu_add;
                alumux_sel = lc3b_ctrl_pkg::alumux_off6;
                d_we_ctl   = 1'b1;
            end
            lc3b_isa_pkg::op_br:   is_br = 1'b1;
            lc3b_isa_pkg::op_jmp:  is_jmp = 1'b1;
            lc3b_isa_pkg::op_trap: is_trap = 1'b1;
            default: ;
        endcase
    end

endmodule : lc3b_control_rom

//--- verilog/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    // ALU function, pass forwards operand a
    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } alu_op_e;

    // Second ALU operand
    typedef enum logic [1:0] {
        alumux_reg,
        alumux_imm5,
        alumux_off6
    } alumux_sel_e;

    // Register file write source
    typedef enum logic {
        wbmux_alu,
        wbmux_mem
    } wbmux_sel_e;

    // Phase of the current APB transfer
    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_state_e;

endpackage : lc3b_ctrl_pkg

//--- verilog/lc3b_isa_pkg.sv
`include "lc3b_pipe_config.svh"

package lc3b_isa_pkg;

    // Architectural word and register index
    typedef logic [`LC3B_WORD_W-1:0] word_t;
    typedef logic [2:0] reg_t;

    // Condition code, bit 2 is n, bit 1 is z, bit 0 is p
    typedef logic [2:0] nzp_t;

    // LC-3b opcode field, IR[15:12]
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_not  = 4'b1001,
        op_jmp  = 4'b1100,
        // Halts the core in this design
        op_trap = 4'b1111
    } opcode_e;

endpackage : lc3b_isa_pkg

//--- include/lc3b_pipe_config.svh
`ifndef LC3B_PIPE_CONFIG_SVH
`define LC3B_PIPE_CONFIG_SVH

// Datapath width and memory depths in words
`define LC3B_WORD_W      16
`define LC3B_IMEM_WORDS  256
`define LC3B_DMEM_WORDS  256

// APB register offsets
`define LC3B_ADDR_CTRL      12'h000
`define LC3B_ADDR_START_PC  12'h004
`define LC3B_ADDR_STATUS    12'h008
`define LC3B_ADDR_RETIRED   12'h00C

// Window bases, one entry per four-byte slot
`define LC3B_WIN_REG   12'h040
`define LC3B_WIN_IMEM  12'h400
`define LC3B_WIN_DMEM  12'h800

`endif
